/* led_panel_pkg.sv */
/*
 * Geometry and scan timing of the 8x8 panel, two half-panels of 4 rows.
 * Timing constants count clk_root cycles or scan ticks, as noted.
 */
package led_panel_pkg;

    localparam int PANEL_WIDTH   = 8;   // columns
    localparam int HALF_ROWS     = 4;   // rows per half-panel
    localparam int COLOR_BITS    = 4;   // bits per colour channel
    localparam int PLANES        = 4;   // bcm bit planes

    localparam int MATRIX_DIV    = 4;   // clk_root cycles per scan tick
    localparam int OE_BASE_TICKS = 2;   // display ticks of plane 0

    // column and row indices within one half-panel
    typedef logic [$clog2(PANEL_WIDTH)-1:0] col_t;
    typedef logic [$clog2(HALF_ROWS)-1:0]   row_t;
    typedef logic [$clog2(PLANES)-1:0]      plane_t;

    // row * PANEL_WIDTH + col, rows 4..7 are the bottom half
    typedef logic [$clog2(2 * HALF_ROWS * PANEL_WIDTH)-1:0] pix_addr_t;

    // red in [11:8], green in [7:4], blue in [3:0]
    typedef logic [3*COLOR_BITS-1:0] pixel_t;

    // bit 0 red, bit 1 green, bit 2 blue
    typedef logic [2:0] rgb_t;

    typedef logic [PLANES-1:0] plane_mask_t;  // one enable per plane

endpackage

/* led_cmd_pkg.sv */
/*
 * Serial command protocol. 8N1 at TICKS_PER_BIT clk_root cycles per bit.
 */
package led_cmd_pkg;

    localparam int TICKS_PER_BIT = 4;

    typedef logic [7:0] byte_t;

    // opcodes, everything else is ignored in IDLE
    localparam byte_t OP_PIXEL  = 8'h50;  // addr, red, green/blue
    localparam byte_t OP_BRIGHT = 8'h42;  // plane mask in low nibble
    localparam byte_t OP_COLOR  = 8'h43;  // rgb enable in low 3 bits

    typedef enum logic [2:0] {
        IDLE,
        ADDR,
        DATA_HI,
        DATA_LO,
        ARG
    } cmd_state_t;

endpackage

/* uart_rx.sv */
/*
 * 8N1 receiver, lsb first. No parity, no framing error output:
 * a frame with a low stop bit is dropped silently.
 */
module uart_rx (
    input  logic               clk_root,
    input  logic               rst_n,
    input  logic               ser_rx,
    output led_cmd_pkg::byte_t rx_byte,
    output logic               rx_strobe
);
    import led_cmd_pkg::*;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;
    typedef logic [$clog2(TICKS_PER_BIT)-1:0] tick_cnt_t;

    rx_state_t rx_state;
    tick_cnt_t tick_cnt;
    logic [2:0] bit_idx;
    logic [1:0] sync_ff;
    logic rx_sync;
    logic bit_done;

    assign rx_sync  = sync_ff[1];
    assign bit_done = (tick_cnt == tick_cnt_t'(TICKS_PER_BIT - 1));

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            sync_ff   <= 2'b11;  // line idles high
            rx_state  <= RX_IDLE;
            tick_cnt  <= '0;
            bit_idx   <= '0;
            rx_strobe <= 1'b0;
        end else begin
            sync_ff   <= {sync_ff[0], ser_rx};
            rx_strobe <= 1'b0;
            tick_cnt  <= tick_cnt + 1'b1;
            case (rx_state)
                RX_IDLE: begin
                    tick_cnt <= '0;
                    if (!rx_sync) rx_state <= RX_START;
                end
                RX_START: begin
                    // recheck in mid start bit, rejects glitches
                    if (tick_cnt == tick_cnt_t'(TICKS_PER_BIT / 2 - 1)) begin
                        tick_cnt <= '0;
                        bit_idx  <= '0;
                        rx_state <= rx_sync ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (bit_done) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) rx_state <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    if (bit_done) begin
                        rx_strobe <= rx_sync;  // low stop bit, no strobe
                        rx_state  <= RX_IDLE;
                    end
                end
                default: rx_state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_root) begin
        if (rx_state == RX_DATA && bit_done) rx_byte <= {rx_sync, rx_byte[7:1]};
    end

endmodule

/* command_decoder.sv */
/*
 * Byte stream to framebuffer writes and display settings.
 * No error recovery: a truncated command waits for its remaining bytes.
 */
module command_decoder (
    input  logic                       clk_root,
    input  logic                       rst_n,
    input  led_cmd_pkg::byte_t         rx_byte,
    input  logic                       rx_strobe,
    output logic                       ram_we,
    output led_panel_pkg::pix_addr_t   ram_waddr,
    output led_panel_pkg::pixel_t      ram_wdata,
    output led_panel_pkg::plane_mask_t brightness_enable,
    output led_panel_pkg::rgb_t        rgb_enable
);
    import led_panel_pkg::*;
    import led_cmd_pkg::*;

    cmd_state_t state;
    logic bright_pending;           // ARG belongs to OP_BRIGHT, else OP_COLOR
    logic [COLOR_BITS-1:0] red_nib;

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            state             <= IDLE;
            bright_pending    <= 1'b0;
            ram_we            <= 1'b0;
            brightness_enable <= '1;
            rgb_enable        <= '1;
        end else begin
            ram_we <= 1'b0;
            if (rx_strobe) begin
                case (state)
                    IDLE: begin
                        if (rx_byte == OP_PIXEL) begin
                            state <= ADDR;
                        end else if (rx_byte == OP_BRIGHT || rx_byte == OP_COLOR) begin
                            state          <= ARG;
                            bright_pending <= (rx_byte == OP_BRIGHT);
                        end
                    end
                    ADDR:    state <= DATA_HI;
                    DATA_HI: state <= DATA_LO;
                    DATA_LO: begin
                        ram_we <= 1'b1;  // one cycle after the last byte
                        state  <= IDLE;
                    end
                    ARG: begin
                        if (bright_pending) brightness_enable <= rx_byte[PLANES-1:0];
                        else rgb_enable <= rx_byte[2:0];
                        state <= IDLE;
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    // pixel assembly
    always_ff @(posedge clk_root) begin
        if (rx_strobe) begin
            if (state == ADDR) ram_waddr <= rx_byte[$bits(pix_addr_t)-1:0];
            if (state == DATA_HI) red_nib <= rx_byte[COLOR_BITS-1:0];
            if (state == DATA_LO) ram_wdata <= {red_nib, rx_byte};
        end
    end

endmodule

/* frame_ram.sv */
/*
 * 64 x 12-bit framebuffer, one write port, two registered read ports.
 * Contents are undefined until written.
 */
module frame_ram (
    input  logic                     clk_root,
    input  logic                     we,
    input  led_panel_pkg::pix_addr_t waddr,
    input  led_panel_pkg::pixel_t    wdata,
    input  led_panel_pkg::pix_addr_t rd_addr_top,
    input  led_panel_pkg::pix_addr_t rd_addr_bottom,
    output led_panel_pkg::pixel_t    rd_data_top,
    output led_panel_pkg::pixel_t    rd_data_bottom
);
    import led_panel_pkg::*;

    pixel_t mem [2*HALF_ROWS*PANEL_WIDTH];

    always_ff @(posedge clk_root) begin
        if (we) mem[waddr] <= wdata;
    end

    // read before write on an address collision
    always_ff @(posedge clk_root) begin
        rd_data_top    <= mem[rd_addr_top];
        rd_data_bottom <= mem[rd_addr_bottom];
    end

endmodule

/* matrix_scan.sv */
/*
 * BCM scan sequencer: per row, planes 3..0, each shifted, latched, then lit.
 * Shifting never overlaps display time. One row is 98 ticks.
 */
module matrix_scan (
    input  logic                  clk_root,
    input  logic                  rst_n,
    output led_panel_pkg::col_t   scan_col,
    output led_panel_pkg::row_t   scan_row,
    output led_panel_pkg::plane_t scan_plane,
    output logic                  clk_pixel,
    output logic                  row_latch,
    output logic                  output_enable,
    output led_panel_pkg::row_t   row_addr
);
    import led_panel_pkg::*;

    typedef enum logic [1:0] {SHIFT_LOW, SHIFT_HIGH, LATCH, DISPLAY} phase_t;
    typedef logic [$clog2(MATRIX_DIV)-1:0] div_t;
    typedef logic [$clog2(OE_BASE_TICKS << (PLANES - 1))-1:0] disp_t;

    phase_t phase;
    div_t   div_cnt;
    disp_t  disp_cnt;  // remaining display ticks minus one
    logic   tick;

    assign tick = (div_cnt == div_t'(MATRIX_DIV - 1));

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) div_cnt <= '0;
        else if (tick) div_cnt <= '0;
        else div_cnt <= div_cnt + 1'b1;
    end

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            phase      <= SHIFT_LOW;
            scan_col   <= '0;
            scan_row   <= '0;
            scan_plane <= plane_t'(PLANES - 1);  // msb plane first
            disp_cnt   <= '0;
        end else if (tick) begin
            case (phase)
                SHIFT_LOW: phase <= SHIFT_HIGH;
                SHIFT_HIGH: begin
                    if (scan_col == col_t'(PANEL_WIDTH - 1)) begin
                        phase <= LATCH;
                    end else begin
                        scan_col <= scan_col + 1'b1;
                        phase    <= SHIFT_LOW;
                    end
                end
                LATCH: begin
                    phase    <= DISPLAY;
                    disp_cnt <= disp_t'((OE_BASE_TICKS << scan_plane) - 1);
                end
                DISPLAY: begin
                    if (disp_cnt == '0) begin
                        phase      <= SHIFT_LOW;
                        scan_col   <= '0;
                        scan_plane <= scan_plane - 1'b1;  // 0 wraps to 3
                        if (scan_plane == '0) scan_row <= scan_row + 1'b1;
                    end else begin
                        disp_cnt <= disp_cnt - 1'b1;
                    end
                end
                default: phase <= SHIFT_LOW;
            endcase
        end
    end

    assign clk_pixel     = (phase == SHIFT_HIGH);
    assign row_latch     = (phase == LATCH);
    assign output_enable = (phase == DISPLAY);

    // follows scan_row one cycle later, oe is low by then
    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) row_addr <= '0;
        else row_addr <= scan_row;
    end

endmodule

/* pixel_fetch.sv */
/*
 * Reads top and bottom pixels of the scan position and reduces them to
 * gated rgb bits. Outputs are valid 2 cycles after a scan position change.
 */
module pixel_fetch (
    input  logic                       clk_root,
    input  logic                       rst_n,
    input  led_panel_pkg::col_t        scan_col,
    input  led_panel_pkg::row_t        scan_row,
    input  led_panel_pkg::plane_t      scan_plane,
    input  led_panel_pkg::pixel_t      rd_data_top,
    input  led_panel_pkg::pixel_t      rd_data_bottom,
    input  led_panel_pkg::plane_mask_t brightness_enable,
    input  led_panel_pkg::rgb_t        rgb_enable,
    output led_panel_pkg::pix_addr_t   rd_addr_top,
    output led_panel_pkg::pix_addr_t   rd_addr_bottom,
    output led_panel_pkg::rgb_t        rgb_top,
    output led_panel_pkg::rgb_t        rgb_bottom
);
    import led_panel_pkg::*;

    // plane bit of each colour nibble, masked by both settings
    function automatic rgb_t plane_bits(pixel_t px, plane_t pl);
        rgb_t bits;
        bits[0] = px[2*COLOR_BITS + pl];  // red
        bits[1] = px[COLOR_BITS + pl];    // green
        bits[2] = px[pl];                 // blue
        return bits & rgb_enable & {3{brightness_enable[pl]}};
    endfunction

    assign rd_addr_top    = pix_addr_t'(scan_row * PANEL_WIDTH + scan_col);
    assign rd_addr_bottom = pix_addr_t'((scan_row + HALF_ROWS) * PANEL_WIDTH + scan_col);

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            rgb_top    <= '0;
            rgb_bottom <= '0;
        end else begin
            rgb_top    <= plane_bits(rd_data_top, scan_plane);
            rgb_bottom <= plane_bits(rd_data_bottom, scan_plane);
        end
    end

endmodule

/* led_matrix_top.sv */
/*
 * Serial-controlled 8x8 HUB75-style panel driver. output_enable is
 * active high here, invert at the pin for a panel with an active low OE.
 */
module led_matrix_top (
    input  logic                  clk_root,
    input  logic                  rst_n,
    input  logic                  ser_rx,
    output led_panel_pkg::rgb_t   rgb_top,
    output led_panel_pkg::rgb_t   rgb_bottom,
    output led_panel_pkg::row_t   row_addr,
    output logic                  clk_pixel,
    output logic                  row_latch,
    output logic                  output_enable
);
    import led_panel_pkg::*;
    import led_cmd_pkg::*;

    byte_t       rx_byte;
    logic        rx_strobe;
    logic        ram_we;
    pix_addr_t   ram_waddr, rd_addr_top, rd_addr_bottom;
    pixel_t      ram_wdata, rd_data_top, rd_data_bottom;
    plane_mask_t brightness_enable;
    rgb_t        rgb_enable;
    col_t        scan_col;
    row_t        scan_row;
    plane_t      scan_plane;

    uart_rx u_uart_rx (.clk_root, .rst_n, .ser_rx, .rx_byte, .rx_strobe);

    command_decoder u_decoder (.clk_root, .rst_n, .rx_byte, .rx_strobe, .ram_we,
        .ram_waddr, .ram_wdata, .brightness_enable, .rgb_enable);

    frame_ram u_ram (.clk_root, .we(ram_we), .waddr(ram_waddr), .wdata(ram_wdata),
        .rd_addr_top, .rd_addr_bottom, .rd_data_top, .rd_data_bottom);

    matrix_scan u_scan (.clk_root, .rst_n, .scan_col, .scan_row, .scan_plane,
        .clk_pixel, .row_latch, .output_enable, .row_addr);

    pixel_fetch u_fetch (.clk_root, .rst_n, .scan_col, .scan_row, .scan_plane,
        .rd_data_top, .rd_data_bottom, .brightness_enable, .rgb_enable,
        .rd_addr_top, .rd_addr_bottom, .rgb_top, .rgb_bottom);

endmodule

/* led_matrix_sva.sv */
/*
 * Panel control protocol checks, bound into led_matrix_top.
 * The output_enable length check expects planes 3, 2, 1, 0 from reset on.
 */
module led_matrix_sva (
    input logic                clk_root,
    input logic                rst_n,
    input logic                clk_pixel,
    input logic                row_latch,
    input logic                output_enable,
    input led_panel_pkg::row_t row_addr
);
    timeunit 1ns;
    timeprecision 100ps;
    import led_panel_pkg::*;

    localparam int LONGEST_OE = MATRIX_DIV * OE_BASE_TICKS * 8;  // plane 3, in cycles

    logic pix_q;
    logic latch_q;
    logic oe_q;
    logic [3:0] pix_edges;      // clk_pixel rises since the last latch
    int unsigned oe_len;
    int unsigned oe_expect;
    int unsigned fail_count = 0;

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            pix_q     <= 1'b0;
            latch_q   <= 1'b0;
            oe_q      <= 1'b0;
            pix_edges <= '0;
            oe_len    <= 0;
            oe_expect <= LONGEST_OE;
        end else begin
            pix_q   <= clk_pixel;
            latch_q <= row_latch;
            oe_q    <= output_enable;
            if (row_latch && !latch_q) pix_edges <= '0;
            else if (clk_pixel && !pix_q) pix_edges <= pix_edges + 4'd1;
            if (output_enable) begin
                oe_len <= oe_len + 1;
            end else if (oe_q) begin
                oe_len    <= 0;
                // 64, 32, 16, 8 cycles, then the next row
                oe_expect <= (oe_expect == LONGEST_OE / 8) ? LONGEST_OE : oe_expect / 2;
            end
        end
    end

    oe_excludes_shift: assert property (@(posedge clk_root) disable iff (!rst_n)
        !(output_enable && (clk_pixel || row_latch)))
        else begin
            $error("output_enable high together with clk_pixel or row_latch");
            fail_count++;
        end

    row_moves_dark: assert property (@(posedge clk_root) disable iff (!rst_n)
        !$stable(row_addr) |-> !output_enable)
        else begin
            $error("row_addr changed while output_enable was high");
            fail_count++;
        end

    eight_shifts: assert property (@(posedge clk_root) disable iff (!rst_n)
        (row_latch && !latch_q) |-> (pix_edges == 4'd8))
        else begin
            $error("row_latch after %0d clk_pixel edges instead of 8", pix_edges);
            fail_count++;
        end

    oe_length: assert property (@(posedge clk_root) disable iff (!rst_n)
        (oe_q && !output_enable) |-> (oe_len == oe_expect))
        else begin
            $error("output_enable pulse of %0d cycles, %0d due", oe_len, oe_expect);
            fail_count++;
        end

endmodule

/* tb_led_matrix.sv */
/*
 * Serial writes into the framebuffer, then checks of rgb_top and rgb_bottom
 * at every clk_pixel rise against a shadow copy. Runs with Verilator --timing.
 */
module tb_led_matrix;
    timeunit 1ns;
    timeprecision 100ps;
    import led_panel_pkg::*;
    import led_cmd_pkg::*;

    localparam int FRAME_CYCLES   = 1568;  // 4 rows of 98 ticks
    localparam int FRAME_CHECKS   = 2 * HALF_ROWS * PLANES * PANEL_WIDTH;
    localparam int TIMEOUT_CYCLES = 40000; // writes, 5 frames, margin

    logic clk_root;
    logic rst_n;
    logic ser_rx;
    rgb_t rgb_top;
    rgb_t rgb_bottom;
    row_t row_addr;
    logic clk_pixel;
    logic row_latch;
    logic output_enable;

    pixel_t      shadow [2*HALF_ROWS*PANEL_WIDTH];
    plane_mask_t shadow_bright = 4'hF;
    rgb_t        shadow_rgb = 3'b111;
    int seed = 32'h3bae;
    int errors = 0;
    int checks = 0;
    int cycle_count = 0;
    bit checking = 1'b0;
    // scan position as seen from the panel pins
    bit synced = 1'b0;
    bit pix_seen = 1'b0;
    bit latch_seen = 1'b0;
    row_t row_seen = '0;
    int col_pos = 0;
    int plane_pos = PLANES - 1;

    led_matrix_top u_dut (.clk_root, .rst_n, .ser_rx, .rgb_top, .rgb_bottom,
        .row_addr, .clk_pixel, .row_latch, .output_enable);

    bind led_matrix_top led_matrix_sva u_sva (.clk_root, .rst_n, .clk_pixel,
        .row_latch, .output_enable, .row_addr);

    initial begin
        clk_root = 1'b0;
        forever #20 clk_root = ~clk_root;
    end

    task automatic expect_value(string name, logic [11:0] got, logic [11:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("MISMATCH %s: expected %h, got %h", name, exp, got);
            errors++;
        end
    endtask

    // plane bit of each nibble, then brightness and colour gating
    function automatic rgb_t expected_rgb(pixel_t px, int pl);
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
        rgb_t lit;
        red   = px[11:8];
        green = px[7:4];
        blue  = px[3:0];
        lit   = {blue[pl], green[pl], red[pl]};
        if (!shadow_bright[pl]) lit = 3'b000;
        return lit & shadow_rgb;
    endfunction

    task automatic check_column(int row, int col, int pl);
        pixel_t top_px;
        pixel_t bot_px;
        top_px = shadow[row * PANEL_WIDTH + col];
        bot_px = shadow[(row + HALF_ROWS) * PANEL_WIDTH + col];
        expect_value($sformatf("rgb_top r%0d c%0d p%0d", row, col, pl),
            rgb_top, expected_rgb(top_px, pl));
        expect_value($sformatf("rgb_bottom r%0d c%0d p%0d", row, col, pl),
            rgb_bottom, expected_rgb(bot_px, pl));
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk_root) begin
        if (row_addr != row_seen) begin  // new row, starts at plane 3
            expect_value("row_addr", row_addr, row_t'(row_seen + 1'b1));
            col_pos   = 0;
            plane_pos = PLANES - 1;
            if (row_addr == '0) synced = 1'b1;
        end
        if (row_latch && !latch_seen) begin
            col_pos   = 0;
            plane_pos = plane_pos - 1;
        end
        if (clk_pixel && !pix_seen) begin
            if (synced && checking) check_column(row_addr, col_pos, plane_pos);
            col_pos++;
        end
        pix_seen   = clk_pixel;
        latch_seen = row_latch;
        row_seen   = row_addr;
    end

    task automatic send_byte(byte_t data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};  // stop, data lsb first, start
        for (int i = 0; i < 10; i++) begin
            @(negedge clk_root);
            ser_rx = frame[i];
            repeat (TICKS_PER_BIT - 1) @(negedge clk_root);
        end
        repeat (TICKS_PER_BIT) @(negedge clk_root);  // one idle bit
    endtask

    task automatic write_pixel(pix_addr_t addr, pixel_t px);
        send_byte(OP_PIXEL);
        send_byte({2'b00, addr});
        send_byte({4'h0, px[11:8]});
        send_byte(px[7:0]);
        shadow[addr] = px;
    endtask

    task automatic apply_setting(byte_t op, byte_t arg);
        send_byte(op);
        send_byte(arg);
        if (op == OP_BRIGHT) shadow_bright = arg[3:0];
        else shadow_rgb = arg[2:0];
    endtask

    task automatic display_frames(int frames, string label);
        int first;
        first = checks;
        @(posedge clk_root);
        checking = 1'b1;
        repeat (frames * FRAME_CYCLES) @(posedge clk_root);
        checking = 1'b0;
        if (checks - first < frames * FRAME_CHECKS - PANEL_WIDTH) begin
            $display("too few data checks during %s: %0d", label, checks - first);
            errors++;
        end
    endtask

    task automatic check_quiet_outputs(bit with_rgb);
        expect_value("clk_pixel", clk_pixel, 12'h0);
        expect_value("row_latch", row_latch, 12'h0);
        expect_value("output_enable", output_enable, 12'h0);
        expect_value("row_addr", row_addr, 12'h0);
        if (with_rgb) begin
            expect_value("rgb_top", rgb_top, 12'h0);
            expect_value("rgb_bottom", rgb_bottom, 12'h0);
        end
    endtask

    initial begin
        rst_n  = 1'b0;
        ser_rx = 1'b1;
        repeat (5) begin
            @(negedge clk_root);
            check_quiet_outputs(1'b1);
        end
        rst_n = 1'b1;
        repeat (3) begin
            @(negedge clk_root);
            check_quiet_outputs(1'b0);  // still in the first shift tick
        end

        for (int a = 0; a < 2 * HALF_ROWS * PANEL_WIDTH; a++) begin
            write_pixel(pix_addr_t'(a), pixel_t'($random(seed)));
        end
        display_frames(2, "framebuffer display");

        send_byte(8'hFF);  // not an opcode
        write_pixel(pix_addr_t'($random(seed)), pixel_t'($random(seed)));
        display_frames(1, "write after unknown opcode");

        apply_setting(OP_BRIGHT, 8'h05);
        display_frames(1, "brightness mask");

        apply_setting(OP_BRIGHT, 8'h0F);
        apply_setting(OP_COLOR, 8'h02);
        display_frames(1, "colour enable");

        $display("errors: %0d mismatches, %0d assertion failures, %0d checks",
            errors, u_dut.u_sva.fail_count, checks);
        if (errors == 0 && u_dut.u_sva.fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_root);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* tb.f */
led_panel_pkg.sv
led_cmd_pkg.sv
uart_rx.sv
command_decoder.sv
frame_ram.sv
matrix_scan.sv
pixel_fetch.sv
led_matrix_top.sv
led_matrix_sva.sv
tb_led_matrix.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_led_matrix -f tb.f -o sim_tb
status=0
./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log
if grep -q "STATUS: FAIL" sim.log || [ "$status" -ne 0 ]; then
    exit 1
fi
